//--- run.sh
#!/usr/bin/env bash
# Builds the request shim testbench with Verilator and runs it.
# The run passes only if the simulator prints the pass line.

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --top-module tb_top \
        -f tb.f --Mdir obj_dir -o tb_sim; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/tb_sim 2>&1)
sim_status=$?
echo "$sim_out"

if [ "$sim_status" -ne 0 ]; then
    echo "Simulator exited with status $sim_status"
    exit 1
fi

if grep -qx "Simulation passed" <<< "$sim_out"; then
    exit 0
fi

echo "Pass line not found in simulator output"
exit 1

//--- src/mpf_buffer_lockstep.sv
// ======================================================================
// Holds channel 0 and channel 1 requests in one FIFO entry
// Both channels leave together, so the consumer must take both or none
// ======================================================================

`timescale 1ns/1ps

`include "mpf_macros.svh"

module mpf_buffer_lockstep import mpf_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_n,

    // Accelerator side, unbuffered
    input  logic [`MPF_HDR_W-1:0]  c0_tx_hdr,
    input  logic                   c0_tx_rd_valid,
    input  c1_hdr_u                c1_tx_hdr,
    input  logic [`MPF_DATA_W-1:0] c1_tx_data,
    input  logic                   c1_tx_wr_valid,
    input  logic                   c1_tx_ir_valid,
    output logic                   tx_alm_full,

    // Head of the buffer toward the issue stage
    output logic [`MPF_HDR_W-1:0]  head_c0_hdr,
    output logic                   head_c0_rd_valid,
    output c1_hdr_u                head_c1_hdr,
    output logic [`MPF_DATA_W-1:0] head_c1_data,
    output logic                   head_c1_wr_valid,
    output logic                   head_c1_ir_valid,
    output logic                   head_not_empty,

    // One strobe moves both channels out of the buffer
    input  logic                   deq_tx
);

    // ==================================================================
    // Entry layout, channel 0 above channel 1
    // ==================================================================

    localparam int C0TX_BITS = `MPF_HDR_W + 1;
    localparam int C1TX_BITS = `MPF_HDR_W + `MPF_DATA_W + 2;
    localparam int TX_BITS   = C0TX_BITS + C1TX_BITS;

    logic               enq_en;
    logic [TX_BITS-1:0] enq_data;
    logic [TX_BITS-1:0] first;

    // Raw valid bits of the head, meaningless while the FIFO is empty
    logic first_rd_valid;
    logic first_wr_valid;
    logic first_ir_valid;

    // Any request on either channel takes a slot for the pair
    assign enq_en = c0_tx_rd_valid || c1_tx_wr_valid || c1_tx_ir_valid;

    // Field order here must match the split of first below
    assign enq_data = {c0_tx_hdr, c0_tx_rd_valid,
                       c1_tx_hdr, c1_tx_data, c1_tx_wr_valid, c1_tx_ir_valid};

    assign {head_c0_hdr, first_rd_valid,
            head_c1_hdr, head_c1_data, first_wr_valid, first_ir_valid} = first;

    assign head_c0_rd_valid = first_rd_valid && head_not_empty;
    assign head_c1_wr_valid = first_wr_valid && head_not_empty;
    assign head_c1_ir_valid = first_ir_valid && head_not_empty;

    mpf_fifo_lutram #(
        .N_DATA_BITS (TX_BITS),
        .N_ENTRIES   (`MPF_N_ENTRIES),
        .THRESHOLD   (`MPF_THRESHOLD)
    ) fifo0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .enq_data    (enq_data),
        .enq_en      (enq_en),
        .first       (first),
        .deq_en      (deq_tx),
        .not_empty   (head_not_empty),
        .almost_full (tx_alm_full)
    );

endmodule

//--- src/mpf_fifo_lutram.sv
// ======================================================================
// Circular FIFO with combinational head and registered almost-full
// Enqueue into a full FIFO or dequeue from an empty one is not blocked
// ======================================================================

`timescale 1ns/1ps

`include "mpf_macros.svh"

module mpf_fifo_lutram #(
    parameter int N_DATA_BITS = 32,
    parameter int N_ENTRIES   = `MPF_N_ENTRIES,
    parameter int THRESHOLD   = `MPF_THRESHOLD
) (
    input  logic                   clk,
    input  logic                   rst_n,

    input  logic [N_DATA_BITS-1:0] enq_data,
    input  logic                   enq_en,

    // Head of the queue, valid while not_empty is high
    output logic [N_DATA_BITS-1:0] first,
    input  logic                   deq_en,
    output logic                   not_empty,

    // Level, high when THRESHOLD or fewer slots are free
    output logic                   almost_full
);

    localparam int PTR_W = (N_ENTRIES > 1) ? $clog2(N_ENTRIES) : 1;
    localparam int CNT_W = $clog2(N_ENTRIES + 1);

    // Occupancy at which free slots reach the threshold
    localparam logic [CNT_W-1:0] AF_LEVEL = CNT_W'(N_ENTRIES - THRESHOLD);
    localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(N_ENTRIES - 1);

    logic [N_DATA_BITS-1:0] mem [N_ENTRIES];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic [CNT_W-1:0] count_next;

    // Head is read straight out of storage so an entry written at one
    // edge is visible right after it
    assign first     = mem[rd_ptr];
    assign not_empty = (count != '0);

    always_comb begin
        case ({enq_en, deq_en})
            2'b10:   count_next = count + CNT_W'(1);
            2'b01:   count_next = count - CNT_W'(1);
            default: count_next = count;
        endcase
    end

    // Storage holds payload only
    always_ff @(posedge clk) begin
        if (enq_en) begin
            mem[wr_ptr] <= enq_data;
        end
    end

    // Pointers wrap explicitly so the depth need not be a power of two
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            count       <= '0;
            almost_full <= 1'b0;
        end else begin
            if (enq_en) begin
                wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + PTR_W'(1);
            end
            if (deq_en) begin
                rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + PTR_W'(1);
            end
            count       <= count_next;
            // Registered from the occupancy this edge leaves behind
            almost_full <= (count_next >= AF_LEVEL);
        end
    end

endmodule

//--- src/mpf_issue.sv
// ======================================================================
// Issue stage from the buffer head onto registered memory request ports
// Vector output is only meaningful while mem_c1_ir_valid is high
// ======================================================================

`timescale 1ns/1ps

`include "mpf_macros.svh"

module mpf_issue import mpf_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_n,

    // Head of the lock-step buffer
    input  logic [`MPF_HDR_W-1:0]  head_c0_hdr,
    input  logic                   head_c0_rd_valid,
    input  c1_hdr_u                head_c1_hdr,
    input  logic [`MPF_DATA_W-1:0] head_c1_data,
    input  logic                   head_c1_wr_valid,
    input  logic                   head_c1_ir_valid,
    input  logic                   head_not_empty,

    // Back-pressure level from the memory side
    input  logic                   mem_alm_full,

    // Dequeue strobe back to the buffer
    output logic                   deq_tx,

    // Memory side request ports, all registered
    output logic [`MPF_HDR_W-1:0]  mem_c0_hdr,
    output logic                   mem_c0_rd_valid,
    output c1_hdr_u                mem_c1_hdr,
    output logic [`MPF_DATA_W-1:0] mem_c1_data,
    output logic                   mem_c1_wr_valid,
    output logic                   mem_c1_ir_valid,
    output logic [`MPF_IRQ_W-1:0]  mem_irq_vector
);

    logic [`MPF_IRQ_W-1:0] irq_vector;

    // ==================================================================
    // Dequeue control
    // ==================================================================

    // Take the head whenever there is one and memory can accept it
    assign deq_tx = head_not_empty && !mem_alm_full;

    // Interrupt entries are read through the interrupt view of the header
    // while writes produce a zero vector
    assign irq_vector = head_c1_ir_valid ? head_c1_hdr.irq.vector : '0;

    // ==================================================================
    // Output registers
    // ==================================================================

    // Valid bits drop in every cycle without a dequeue
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_c0_rd_valid <= 1'b0;
            mem_c1_wr_valid <= 1'b0;
            mem_c1_ir_valid <= 1'b0;
        end else begin
            mem_c0_rd_valid <= deq_tx && head_c0_rd_valid;
            mem_c1_wr_valid <= deq_tx && head_c1_wr_valid;
            mem_c1_ir_valid <= deq_tx && head_c1_ir_valid;
        end
    end

    // Payload follows the head only on a dequeue and holds otherwise
    always_ff @(posedge clk) begin
        if (deq_tx) begin
            mem_c0_hdr     <= head_c0_hdr;
            mem_c1_hdr     <= head_c1_hdr;
            mem_c1_data    <= head_c1_data;
            mem_irq_vector <= irq_vector;
        end
    end

endmodule

//--- src/mpf_macros.svh
// ======================================================================
// Field widths and FIFO sizing shared by the request shim and its bench
// Both request headers must share MPF_HDR_W so one union covers channel 1
// ======================================================================

`ifndef MPF_MACROS_SVH
`define MPF_MACROS_SVH

// Memory request header fields
`define MPF_ADDR_W      16
`define MPF_MDATA_W     8
`define MPF_HDR_W       (`MPF_ADDR_W + `MPF_MDATA_W)

// Write payload carried on channel 1
`define MPF_DATA_W      32

// Interrupt vector width in the channel 1 interrupt reading
`define MPF_IRQ_W       8

// Almost-full asserts once free slots drop to this count or fewer
`define MPF_THRESHOLD   4

// Four slots beyond the threshold keep streaming possible below it
`define MPF_N_ENTRIES   (`MPF_THRESHOLD + 4)

`endif

//--- src/mpf_pkg.sv
// ======================================================================
// Channel 1 header types for the request shim
// Both readings are exactly MPF_HDR_W bits wide and share the tag field
// ======================================================================

`include "mpf_macros.svh"

package mpf_pkg;

    // Write reading of the channel 1 header
    // Address sits on top, tag in the low byte, like channel 0
    typedef struct packed {
        logic [`MPF_ADDR_W-1:0]  addr;
        logic [`MPF_MDATA_W-1:0] mdata;
    } wr_hdr_t;

    // Interrupt reading of the same word
    // The vector takes the top byte and the middle bits are reserved
    typedef struct packed {
        logic [`MPF_IRQ_W-1:0]                           vector;
        logic [`MPF_HDR_W-`MPF_IRQ_W-`MPF_MDATA_W-1:0]   rsvd;
        logic [`MPF_MDATA_W-1:0]                         mdata;
    } irq_hdr_t;

    // ==================================================================
    // One header word, two decodings
    // ==================================================================

    // The valid bit that travels with the header selects the reading
    // A write uses wr, an interrupt uses irq
    typedef union packed {
        wr_hdr_t  wr;
        irq_hdr_t irq;
    } c1_hdr_u;

endpackage

//--- src/mpf_shim_top.sv
// ======================================================================
// Request-side shim, lock-step buffer followed by the issue stage
// Accelerator must stop within MPF_THRESHOLD cycles of tx_alm_full
// ======================================================================

`timescale 1ns/1ps

`include "mpf_macros.svh"

module mpf_shim_top import mpf_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_n,

    // Accelerator side
    input  logic [`MPF_HDR_W-1:0]  c0_tx_hdr,
    input  logic                   c0_tx_rd_valid,
    input  c1_hdr_u                c1_tx_hdr,
    input  logic [`MPF_DATA_W-1:0] c1_tx_data,
    input  logic                   c1_tx_wr_valid,
    input  logic                   c1_tx_ir_valid,
    output logic                   tx_alm_full,

    // Memory side
    output logic [`MPF_HDR_W-1:0]  mem_c0_hdr,
    output logic                   mem_c0_rd_valid,
    output c1_hdr_u                mem_c1_hdr,
    output logic [`MPF_DATA_W-1:0] mem_c1_data,
    output logic                   mem_c1_wr_valid,
    output logic                   mem_c1_ir_valid,
    output logic [`MPF_IRQ_W-1:0]  mem_irq_vector,
    input  logic                   mem_alm_full
);

    // Buffer head toward the issue stage
    logic [`MPF_HDR_W-1:0]  head_c0_hdr;
    logic                   head_c0_rd_valid;
    c1_hdr_u                head_c1_hdr;
    logic [`MPF_DATA_W-1:0] head_c1_data;
    logic                   head_c1_wr_valid;
    logic                   head_c1_ir_valid;
    logic                   head_not_empty;
    logic                   deq_tx;

    mpf_buffer_lockstep buf0 (
        .clk              (clk),
        .rst_n            (rst_n),
        .c0_tx_hdr        (c0_tx_hdr),
        .c0_tx_rd_valid   (c0_tx_rd_valid),
        .c1_tx_hdr        (c1_tx_hdr),
        .c1_tx_data       (c1_tx_data),
        .c1_tx_wr_valid   (c1_tx_wr_valid),
        .c1_tx_ir_valid   (c1_tx_ir_valid),
        .tx_alm_full      (tx_alm_full),
        .head_c0_hdr      (head_c0_hdr),
        .head_c0_rd_valid (head_c0_rd_valid),
        .head_c1_hdr      (head_c1_hdr),
        .head_c1_data     (head_c1_data),
        .head_c1_wr_valid (head_c1_wr_valid),
        .head_c1_ir_valid (head_c1_ir_valid),
        .head_not_empty   (head_not_empty),
        .deq_tx           (deq_tx)
    );

    // Two edges from accelerator input to memory output without stalls
    mpf_issue issue0 (
        .clk              (clk),
        .rst_n            (rst_n),
        .head_c0_hdr      (head_c0_hdr),
        .head_c0_rd_valid (head_c0_rd_valid),
        .head_c1_hdr      (head_c1_hdr),
        .head_c1_data     (head_c1_data),
        .head_c1_wr_valid (head_c1_wr_valid),
        .head_c1_ir_valid (head_c1_ir_valid),
        .head_not_empty   (head_not_empty),
        .mem_alm_full     (mem_alm_full),
        .deq_tx           (deq_tx),
        .mem_c0_hdr       (mem_c0_hdr),
        .mem_c0_rd_valid  (mem_c0_rd_valid),
        .mem_c1_hdr       (mem_c1_hdr),
        .mem_c1_data      (mem_c1_data),
        .mem_c1_wr_valid  (mem_c1_wr_valid),
        .mem_c1_ir_valid  (mem_c1_ir_valid),
        .mem_irq_vector   (mem_irq_vector)
    );

endmodule

//--- tb.f
+incdir+src
src/mpf_pkg.sv
src/mpf_fifo_lutram.sv
src/mpf_buffer_lockstep.sv
src/mpf_issue.sv
src/mpf_shim_top.sv
verif/tb_clkgen.sv
verif/mpf_shim_assert.sv
verif/tb_top.sv

//--- verif/mpf_shim_assert.sv
// ======================================================================
// Protocol checks bound into the lock-step buffer
// Occupancy is tracked here from the enqueue and dequeue strobes
// ======================================================================

`timescale 1ns/1ps

`include "mpf_macros.svh"

module mpf_shim_assert (
    input logic clk,
    input logic rst_n,
    input logic enq_en,
    input logic deq_tx,
    input logic head_c1_wr_valid,
    input logic head_c1_ir_valid
);

    localparam int CNT_W = $clog2(`MPF_N_ENTRIES + 1);

    logic [CNT_W-1:0] occupancy;

    // Shadow of the FIFO fill level that moves one step per strobe
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            occupancy <= '0;
        end else if (enq_en && !deq_tx) begin
            occupancy <= occupancy + CNT_W'(1);
        end else if (!enq_en && deq_tx) begin
            occupancy <= occupancy - CNT_W'(1);
        end
    end

    // ==================================================================
    // Properties
    // ==================================================================

    no_enq_when_full: assert property (@(posedge clk) disable iff (!rst_n)
        (occupancy == CNT_W'(`MPF_N_ENTRIES)) |-> !enq_en)
        else $error("Enqueue while the FIFO holds all its entries");

    // The shadow count gives an empty flag independent of the FIFO's own
    no_deq_when_empty: assert property (@(posedge clk) disable iff (!rst_n)
        (occupancy == '0) |-> !deq_tx)
        else $error("Dequeue strobe raised on an empty FIFO");

    // The memory valid bits are loaded from these head bits on a dequeue
    wr_ir_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        deq_tx |-> !(head_c1_wr_valid && head_c1_ir_valid))
        else $error("Write and interrupt valid issued together");

endmodule

//--- verif/tb_clkgen.sv
// ======================================================================
// Free-running clock and an active-low reset for the shim testbench
// Reset is released on a falling edge, after RESET_CYCLES rising edges
// ======================================================================

`timescale 1ns/1ps

module tb_clkgen #(
    parameter int PERIOD_NS    = 4,
    parameter int RESET_CYCLES = 8
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // Release away from the rising edge so no flop sees it change there
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

//--- verif/tb_top.sv
// ======================================================================
// Testbench for the request shim with stimulus on falling edges
// Expected values come from ref_issue, compared on every rising edge
// ======================================================================

`timescale 1ns/1ps

`include "mpf_macros.svh"

module tb_top import mpf_pkg::*; ();

    localparam int CLK_PERIOD = 4;
    localparam int N_ORDER = 12;
    localparam int N_IRQ = 8;
    localparam int N_AF = 4;
    localparam int N_RAND = 200;
    localparam int TOTAL_REQS = N_ORDER + N_IRQ + N_AF + N_RAND;
    localparam int WATCHDOG_CYCLES = TOTAL_REQS * 20 + 500;

    typedef struct packed {
        logic [`MPF_HDR_W-1:0]  c0_hdr;
        logic                   rd_valid;
        logic [`MPF_HDR_W-1:0]  c1_hdr;
        logic [`MPF_DATA_W-1:0] c1_data;
        logic                   wr_valid;
        logic                   ir_valid;
    } req_t;

    typedef struct packed {
        req_t                  req;
        logic [`MPF_IRQ_W-1:0] vector;
    } exp_t;

    logic clk;
    logic rst_n;
    logic [`MPF_HDR_W-1:0]  c0_tx_hdr;
    logic                   c0_tx_rd_valid;
    c1_hdr_u                c1_tx_hdr;
    logic [`MPF_DATA_W-1:0] c1_tx_data;
    logic                   c1_tx_wr_valid;
    logic                   c1_tx_ir_valid;
    logic                   tx_alm_full;
    logic [`MPF_HDR_W-1:0]  mem_c0_hdr;
    logic                   mem_c0_rd_valid;
    c1_hdr_u                mem_c1_hdr;
    logic [`MPF_DATA_W-1:0] mem_c1_data;
    logic                   mem_c1_wr_valid;
    logic                   mem_c1_ir_valid;
    logic [`MPF_IRQ_W-1:0]  mem_irq_vector;
    logic                   mem_alm_full;

    // Sent requests with the edge that enqueued them
    req_t   sent_q[$];
    int     edge_q[$];
    bit     lat_q[$];
    int     edge_cnt = 0;
    int     checks = 0;
    int     value_errors = 0;
    int     other_errors = 0;
    integer seed = 44;
    string  test_name = "reset";

    tb_clkgen #(.PERIOD_NS(CLK_PERIOD), .RESET_CYCLES(8)) clkgen0 (.clk(clk), .rst_n(rst_n));

    mpf_shim_top dut0 (
        .clk(clk), .rst_n(rst_n),
        .c0_tx_hdr(c0_tx_hdr), .c0_tx_rd_valid(c0_tx_rd_valid),
        .c1_tx_hdr(c1_tx_hdr), .c1_tx_data(c1_tx_data),
        .c1_tx_wr_valid(c1_tx_wr_valid), .c1_tx_ir_valid(c1_tx_ir_valid),
        .tx_alm_full(tx_alm_full),
        .mem_c0_hdr(mem_c0_hdr), .mem_c0_rd_valid(mem_c0_rd_valid),
        .mem_c1_hdr(mem_c1_hdr), .mem_c1_data(mem_c1_data),
        .mem_c1_wr_valid(mem_c1_wr_valid), .mem_c1_ir_valid(mem_c1_ir_valid),
        .mem_irq_vector(mem_irq_vector), .mem_alm_full(mem_alm_full)
    );

    bind mpf_buffer_lockstep mpf_shim_assert assert0 (
        .clk(clk), .rst_n(rst_n), .enq_en(enq_en), .deq_tx(deq_tx),
        .head_c1_wr_valid(head_c1_wr_valid), .head_c1_ir_valid(head_c1_ir_valid)
    );

    // ==================================================================
    // Reference model and helpers
    // ==================================================================

    // Issue passes everything through; the vector is the top header byte
    function automatic exp_t ref_issue(input req_t r);
        exp_t e;
        e.req = r;
        e.vector = r.ir_valid ? r.c1_hdr[`MPF_HDR_W-1 -: `MPF_IRQ_W] : '0;
        return e;
    endfunction

    task automatic check_field(input string field, input logic [31:0] exp,
                               input logic [31:0] act);
        checks++;
        assert (exp === act) else begin
            value_errors++;
            $display("** Error in %s, %s: expected %0h, actual %0h",
                     test_name, field, exp, act);
        end
    endtask

    task automatic rand_word(output logic [31:0] w);
        w = $random(seed);
    endtask

    // Kind 0 read, 1 write, 2 read and write, 3 interrupt, 4 read and interrupt
    task automatic build_req(input int kind, output req_t r);
        logic [31:0] w0;
        logic [31:0] w1;
        logic [31:0] w2;
        c1_hdr_u     h;
        rand_word(w0);
        rand_word(w1);
        rand_word(w2);
        r.c0_hdr   = w0[`MPF_HDR_W-1:0];
        r.rd_valid = (kind == 0 || kind == 2 || kind == 4);
        r.c1_data  = w1;
        r.wr_valid = (kind == 1 || kind == 2);
        r.ir_valid = (kind == 3 || kind == 4);
        // Interrupt headers are built through their own view of the word
        if (r.ir_valid) begin
            h.irq.vector = w2[7:0];
            h.irq.rsvd   = '0;
            h.irq.mdata  = w2[15:8];
        end else begin
            h.wr.addr  = w2[15:0];
            h.wr.mdata = w2[23:16];
        end
        r.c1_hdr = h;
    endtask

    // Called on a falling edge, returns on the next one with valids low
    task automatic send_req(input req_t r, input bit lat);
        c0_tx_hdr      = r.c0_hdr;
        c0_tx_rd_valid = r.rd_valid;
        c1_tx_hdr      = r.c1_hdr;
        c1_tx_data     = r.c1_data;
        c1_tx_wr_valid = r.wr_valid;
        c1_tx_ir_valid = r.ir_valid;
        sent_q.push_back(r);
        edge_q.push_back(edge_cnt + 1);
        lat_q.push_back(lat);
        @(negedge clk);
        c0_tx_rd_valid = 1'b0;
        c1_tx_wr_valid = 1'b0;
        c1_tx_ir_valid = 1'b0;
    endtask

    task automatic check_idle_outputs();
        check_field("tx_alm_full", 32'd0, 32'(tx_alm_full));
        check_field("mem_c0_rd_valid", 32'd0, 32'(mem_c0_rd_valid));
        check_field("mem_c1_wr_valid", 32'd0, 32'(mem_c1_wr_valid));
        check_field("mem_c1_ir_valid", 32'd0, 32'(mem_c1_ir_valid));
    endtask

    task automatic wait_drained(input int max_cycles);
        int n;
        n = 0;
        while (sent_q.size() != 0 && n < max_cycles) begin
            @(negedge clk);
            n++;
        end
        assert (sent_q.size() == 0) else begin
            other_errors++;
            $display("Test %s left %0d requests undelivered after %0d cycles",
                     test_name, sent_q.size(), max_cycles);
        end
    endtask

    // ==================================================================
    // Comparison on every rising edge
    // ==================================================================

    always @(posedge clk) begin : compare
        req_t got;
        exp_t e;
        int   enq_edge;
        bit   lat;
        edge_cnt = edge_cnt + 1;
        assert (!(mem_c1_wr_valid && mem_c1_ir_valid)) else begin
            other_errors++;
            $display("Write and interrupt valid are both high on the memory side");
        end
        if (rst_n && (mem_c0_rd_valid || mem_c1_wr_valid || mem_c1_ir_valid)) begin
            if (sent_q.size() == 0) begin
                other_errors++;
                $display("Memory request seen in %s with nothing outstanding", test_name);
            end else begin
                e = ref_issue(sent_q.pop_front());
                enq_edge = edge_q.pop_front();
                lat = lat_q.pop_front();
                got = '{mem_c0_hdr, mem_c0_rd_valid, mem_c1_hdr, mem_c1_data,
                        mem_c1_wr_valid, mem_c1_ir_valid};
                check_field("c0_hdr", 32'(e.req.c0_hdr), 32'(got.c0_hdr));
                check_field("c0_rd_valid", 32'(e.req.rd_valid), 32'(got.rd_valid));
                check_field("c1_hdr", 32'(e.req.c1_hdr), 32'(got.c1_hdr));
                check_field("c1_data", e.req.c1_data, got.c1_data);
                check_field("c1_wr_valid", 32'(e.req.wr_valid), 32'(got.wr_valid));
                check_field("c1_ir_valid", 32'(e.req.ir_valid), 32'(got.ir_valid));
                check_field("irq_vector", 32'(e.vector), 32'(mem_irq_vector));
                // Loaded one edge after the enqueue, sampled on the edge after that
                if (lat) begin
                    check_field("arrival edge", 32'(enq_edge + 2), 32'(edge_cnt));
                end
            end
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles, the tests did not finish",
                 WATCHDOG_CYCLES);
        $display("Simulation failed");
        $finish;
    end

    // ==================================================================
    // Stimulus
    // ==================================================================

    initial begin
        req_t        r;
        logic [31:0] w;
        int          sent;
        c0_tx_hdr = '0;
        c0_tx_rd_valid = 1'b0;
        c1_tx_hdr = '0;
        c1_tx_data = '0;
        c1_tx_wr_valid = 1'b0;
        c1_tx_ir_valid = 1'b0;
        mem_alm_full = 1'b0;

        // Outputs stay quiet through reset and on the first edge after it
        @(posedge clk);
        repeat (6) begin
            @(negedge clk);
            check_idle_outputs();
        end
        wait (rst_n === 1'b1);
        @(negedge clk);
        check_idle_outputs();

        test_name = "lockstep_order";
        for (int i = 0; i < N_ORDER; i++) begin
            build_req(i % 3, r);
            send_req(r, 1'b1);
            if (i % 4 == 3) @(negedge clk);
        end
        wait_drained(50);

        test_name = "irq_decode";
        for (int i = 0; i < N_IRQ; i++) begin
            build_req((i % 2 == 1) ? 1 : ((i % 4 == 0) ? 3 : 4), r);
            send_req(r, 1'b1);
        end
        wait_drained(50);

        // Four entries held back by the memory side cross the threshold
        test_name = "almost_full";
        mem_alm_full = 1'b1;
        for (int i = 0; i < N_AF; i++) begin
            build_req(2, r);
            send_req(r, 1'b0);
            check_field("tx_alm_full", 32'(i >= 3), 32'(tx_alm_full));
        end
        repeat (3) @(negedge clk);
        check_field("tx_alm_full held", 32'd1, 32'(tx_alm_full));
        mem_alm_full = 1'b0;
        @(negedge clk);
        check_field("tx_alm_full drained", 32'd0, 32'(tx_alm_full));
        wait_drained(50);

        // Random traffic in which the driver holds off while almost-full is high
        test_name = "random";
        sent = 0;
        while (sent < N_RAND) begin
            rand_word(w);
            mem_alm_full = (w[1:0] == 2'b00);
            if (!tx_alm_full && w[4:2] != 3'b000) begin
                build_req(int'(w[15:8]) % 5, r);
                send_req(r, 1'b0);
                sent++;
            end else begin
                @(negedge clk);
            end
        end
        mem_alm_full = 1'b0;
        wait_drained(100);

        $display("Checks run: %0d, value errors: %0d, other errors: %0d",
                 checks, value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule
